// ==== common/cache_cfg.svh ====
// ----------------------------------------
// Sizing macros for the cache response
// stage, shared by the package and the RTL
// ----------------------------------------

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Read word and address widths
`define CACHE_DATA_W     32
`define CACHE_ADDR_W     32

// Response FIFO geometry
`define RESP_FIFO_DEPTH  16
`define RESP_PROG_THRESH 8

// Output fan-out
`define NUM_REQUESTOR    2

// Clearing window after reset, in cycles
`define RESP_BUSY_CYCLES 8

`endif

// ==== common/cache_pkg.sv ====
// ----------------------------------------
// Types for the cache response stage
// Referenced by scoped name from all RTL
// ----------------------------------------

`include "cache_cfg.svh"

package cache_pkg;

  // Buffer class carried with every request
  typedef enum logic [2:0] {
    subclass_none     = 3'd0,
    subclass_cu_setup = 3'd1,
    subclass_vertex   = 3'd2,
    subclass_edge     = 3'd3,
    subclass_aux      = 3'd4
  } buffer_subclass_e;

  // Command kind
  typedef enum logic [1:0] {
    cmd_read         = 2'd0,
    cmd_write        = 2'd1,
    cmd_mem_response = 2'd2
  } mem_cmd_e;

  // Routing and class info that follows the data
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] address;
    logic [3:0]               route;
    buffer_subclass_e         subclass;
    logic [1:0]               operand;
    logic [1:0]               filter;
    logic [1:0]               alu;
    mem_cmd_e                 cmd;
  } response_meta_t;

  // Response as delivered by the cache
  typedef struct packed {
    logic                     valid;
    response_meta_t           meta;
    logic [`CACHE_DATA_W-1:0] rdata;
  } cache_response_t;

  // One FIFO entry
  typedef struct packed {
    response_meta_t           meta;
    logic [`CACHE_DATA_W-1:0] rdata;
  } response_payload_t;

  // Output packet, read word copied into all fields
  typedef struct packed {
    logic                     valid;
    response_meta_t           meta;
    logic [`CACHE_DATA_W-1:0] field_0;
    logic [`CACHE_DATA_W-1:0] field_1;
    logic [`CACHE_DATA_W-1:0] field_2;
    logic [`CACHE_DATA_W-1:0] field_3;
  } memory_packet_t;

endpackage

// ==== common/response_fifo_if.sv ====
// ----------------------------------------
// Push, pop and status bundle of the
// response FIFO
// ----------------------------------------

`timescale 1ns/1ps

interface response_fifo_if;

  // Push side
  logic                         wr_en;
  cache_pkg::response_payload_t din;

  // Pop side
  logic                         rd_en;
  cache_pkg::response_payload_t dout;
  logic                         dout_valid;

  // Status
  logic                         empty;
  logic                         full;
  logic                         prog_full;
  logic                         busy;

  modport fifo (
    input  wr_en, din, rd_en,
    output dout, dout_valid, empty, full, prog_full, busy
  );

  // Strobe generation
  modport control (
    output wr_en, rd_en,
    input  empty, full, busy
  );

  // Packet builder downstream of the FIFO
  modport consumer (
    input dout, dout_valid
  );

endinterface

// ==== hw/response_control.sv ====
// ----------------------------------------
// Control of the response stage
// Fans out resets, forms push and pop
// strobes, drives the setup signal
// ----------------------------------------

`timescale 1ns/1ps

module response_control (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic response_in_valid,
  input  logic read_enable,
  response_fifo_if.control fifo,
  output logic reset_fifo,
  output logic reset_router,
  output logic reset_regs,
  output logic fifo_setup_signal
);

  logic push_q;
  logic rd_level_q;

  // ----------------------------------------
  // Reset fan-out
  // ----------------------------------------
  // One register per consumer to ease timing on the reset tree
  always_ff @(posedge ap_clk) begin
    reset_fifo   <= areset_control;
    reset_router <= areset_control;
    reset_regs   <= areset_control;
  end

  // ----------------------------------------
  // Push and pop strobes
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      push_q     <= 1'b0;
      rd_level_q <= 1'b0;
    end else begin
      push_q     <= response_in_valid;
      rd_level_q <= read_enable;
    end
  end

  // Push one cycle after the input strobe
  assign fifo.wr_en = push_q;

  // Pop only with data present
  assign fifo.rd_en = rd_level_q & ~fifo.empty;

  // Setup held through reset and the FIFO clearing window
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_setup_signal <= 1'b1;
    end else begin
      fifo_setup_signal <= fifo.busy;
    end
  end

  // Clearing window keeps the FIFO empty, so no pop lands in it
  a_no_pop_busy : assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo.rd_en |-> !fifo.busy);

  // Push into a full FIFO without a pop leaves it full
  a_full_holds : assert property (@(posedge ap_clk) disable iff (areset_control)
    (fifo.wr_en && fifo.full && !fifo.rd_en) |=> fifo.full);

endmodule

// ==== hw/response_fifo/response_fifo.sv ====
// ----------------------------------------
// Synchronous response FIFO
// Registered read data with a one-cycle
// valid pulse, busy window after reset
// ----------------------------------------

`timescale 1ns/1ps

`include "cache_cfg.svh"

module response_fifo (
  input logic ap_clk,
  input logic reset_fifo,
  response_fifo_if.fifo fifo
);

  localparam int DEPTH  = `RESP_FIFO_DEPTH;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int BUSY_W = $clog2(`RESP_BUSY_CYCLES + 1);

  cache_pkg::response_payload_t mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;
  logic              do_write;
  logic              do_read;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Status
  // ----------------------------------------
  assign fifo.busy      = (busy_cnt != '0);
  assign fifo.full      = (count == CNT_W'(DEPTH));
  assign fifo.empty     = (count == '0);
  assign fifo.prog_full = (count >= CNT_W'(`RESP_PROG_THRESH));

  // Traffic ignored while clearing
  assign do_write = fifo.wr_en & ~fifo.full & ~fifo.busy;
  assign do_read  = fifo.rd_en & ~fifo.empty & ~fifo.busy;

  // Clearing window, counts down once reset is released
  always_ff @(posedge ap_clk) begin
    if (reset_fifo) begin
      busy_cnt <= BUSY_W'(`RESP_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // ----------------------------------------
  // Pointers, occupancy, read valid
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (reset_fifo) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      fifo.dout_valid <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      fifo.dout_valid <= do_read;
    end
  end

  // Storage and read data register
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= fifo.din;
    end
    if (do_read) begin
      fifo.dout <= mem[rd_ptr];
    end
  end

  a_count_bound : assert property (@(posedge ap_clk) disable iff (reset_fifo)
    count <= CNT_W'(DEPTH));

endmodule

// ==== hw/response_router.sv ====
// ----------------------------------------
// Packet builder and requestor demux
// CU setup goes to all requestors, the
// rest to the last one only
// ----------------------------------------

`timescale 1ns/1ps

`include "cache_cfg.svh"

module response_router (
  input  logic ap_clk,
  input  logic reset_router,
  response_fifo_if.consumer fifo,
  output cache_pkg::memory_packet_t response_out [`NUM_REQUESTOR]
);

  localparam int NREQ = `NUM_REQUESTOR;

  logic                      is_setup;
  cache_pkg::memory_packet_t pkt_next;
  logic [NREQ-1:0]           valid_q;
  cache_pkg::memory_packet_t pkt_q [NREQ];

  assign is_setup = (fifo.dout.meta.subclass == cache_pkg::subclass_cu_setup);

  // Read word fanned into every data field
  always_comb begin
    pkt_next.valid   = fifo.dout_valid;
    pkt_next.meta    = fifo.dout.meta;
    pkt_next.field_0 = fifo.dout.rdata;
    pkt_next.field_1 = fifo.dout.rdata;
    pkt_next.field_2 = fifo.dout.rdata;
    pkt_next.field_3 = fifo.dout.rdata;
  end

  // ----------------------------------------
  // Per-requestor output registers
  // ----------------------------------------
  for (genvar i = 0; i < NREQ; i++) begin : g_req
    logic sel;

    // Last requestor takes every response
    assign sel = fifo.dout_valid & (is_setup | (i == NREQ - 1));

    always_ff @(posedge ap_clk) begin
      if (reset_router) begin
        valid_q[i] <= 1'b0;
      end else begin
        valid_q[i] <= sel;
      end
    end

    always_ff @(posedge ap_clk) begin
      if (sel) begin
        pkt_q[i] <= pkt_next;
      end
    end

    always_comb begin
      response_out[i]       = pkt_q[i];
      response_out[i].valid = valid_q[i];
    end
  end

  // Requestor 0 only ever sees CU setup traffic
  a_req0_setup_only : assert property (@(posedge ap_clk) disable iff (reset_router)
    valid_q[0] |-> (pkt_q[0].meta.subclass == cache_pkg::subclass_cu_setup));

endmodule

// ==== hw/cache_response_top.sv ====
// ----------------------------------------
// Cache response stage top level
// Plain ports in, FIFO in the middle,
// flattened requestor packets out
// ----------------------------------------

`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_response_top (
  input  logic                     ap_clk,
  input  logic                     areset_control,
  input  logic                     response_in_valid,
  input  logic [`CACHE_ADDR_W-1:0] response_in_address,
  input  logic [3:0]               response_in_route,
  input  logic [2:0]               response_in_subclass,
  input  logic [1:0]               response_in_operand,
  input  logic [1:0]               response_in_filter,
  input  logic [1:0]               response_in_alu,
  input  logic [`CACHE_DATA_W-1:0] response_in_rdata,
  input  logic                     read_enable,
  output logic [`NUM_REQUESTOR-1:0] response_out_valid,
  output logic [`CACHE_ADDR_W-1:0] response_out_address [`NUM_REQUESTOR],
  output logic [3:0]               response_out_route   [`NUM_REQUESTOR],
  output logic [2:0]               response_out_subclass[`NUM_REQUESTOR],
  output logic [1:0]               response_out_cmd     [`NUM_REQUESTOR],
  output logic [`CACHE_DATA_W-1:0] response_out_field_0 [`NUM_REQUESTOR],
  output logic [`CACHE_DATA_W-1:0] response_out_field_1 [`NUM_REQUESTOR],
  output logic [`CACHE_DATA_W-1:0] response_out_field_2 [`NUM_REQUESTOR],
  output logic [`CACHE_DATA_W-1:0] response_out_field_3 [`NUM_REQUESTOR],
  output logic                     fifo_full,
  output logic                     fifo_prog_full,
  output logic                     fifo_empty_n,
  output logic                     fifo_setup_signal
);

  logic                         reset_fifo;
  logic                         reset_router;
  logic                         reset_regs;
  cache_pkg::cache_response_t   response_in;
  cache_pkg::response_payload_t payload_q;
  cache_pkg::memory_packet_t    router_out [`NUM_REQUESTOR];

  response_fifo_if resp_if ();

  // Cache response from plain ports, a read reply
  always_comb begin
    response_in.valid         = response_in_valid;
    response_in.meta.address  = response_in_address;
    response_in.meta.route    = response_in_route;
    response_in.meta.subclass = cache_pkg::buffer_subclass_e'(response_in_subclass);
    response_in.meta.operand  = response_in_operand;
    response_in.meta.filter   = response_in_filter;
    response_in.meta.alu      = response_in_alu;
    response_in.meta.cmd      = cache_pkg::cmd_read;
    response_in.rdata         = response_in_rdata;
  end

  // Input payload register, command rewritten on the way in
  always_ff @(posedge ap_clk) begin
    payload_q.meta     <= response_in.meta;
    payload_q.meta.cmd <= cache_pkg::cmd_mem_response;
    payload_q.rdata    <= response_in.rdata;
  end

  assign resp_if.din = payload_q;

  // ----------------------------------------
  // Submodules
  // ----------------------------------------
  response_control i_response_control (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .response_in_valid (response_in.valid),
    .read_enable       (read_enable),
    .fifo              (resp_if.control),
    .reset_fifo        (reset_fifo),
    .reset_router      (reset_router),
    .reset_regs        (reset_regs),
    .fifo_setup_signal (fifo_setup_signal)
  );

  response_fifo i_response_fifo (
    .ap_clk     (ap_clk),
    .reset_fifo (reset_fifo),
    .fifo       (resp_if.fifo)
  );

  response_router i_response_router (
    .ap_clk       (ap_clk),
    .reset_router (reset_router),
    .fifo         (resp_if.consumer),
    .response_out (router_out)
  );

  // Registered status toward the upstream block
  always_ff @(posedge ap_clk) begin
    if (reset_regs) begin
      fifo_full      <= 1'b0;
      fifo_prog_full <= 1'b0;
      fifo_empty_n   <= 1'b0;
    end else begin
      fifo_full      <= resp_if.full;
      fifo_prog_full <= resp_if.prog_full;
      fifo_empty_n   <= ~resp_if.empty;
    end
  end

  // Flatten packets onto plain ports
  for (genvar i = 0; i < `NUM_REQUESTOR; i++) begin : g_flat
    assign response_out_valid[i]    = router_out[i].valid;
    assign response_out_address[i]  = router_out[i].meta.address;
    assign response_out_route[i]    = router_out[i].meta.route;
    assign response_out_subclass[i] = router_out[i].meta.subclass;
    assign response_out_cmd[i]      = router_out[i].meta.cmd;
    assign response_out_field_0[i]  = router_out[i].field_0;
    assign response_out_field_1[i]  = router_out[i].field_1;
    assign response_out_field_2[i]  = router_out[i].field_2;
    assign response_out_field_3[i]  = router_out[i].field_3;
  end

endmodule

// ==== verif/tb_cache_response.sv ====
// ----------------------------------------
// Testbench for the cache response stage
// Table-driven stimulus, queue model of the
// FIFO, checks at the falling clock edge
// ----------------------------------------

`timescale 1ns/1ps

`include "cache_cfg.svh"

module tb_cache_response;

  localparam int NREQ  = `NUM_REQUESTOR;
  localparam int DEPTH = `RESP_FIFO_DEPTH;
  localparam int BUSY  = `RESP_BUSY_CYCLES;

  // Subclass and command codes
  localparam logic [2:0] SUB_CU_SETUP = 3'd1;
  localparam logic [2:0] SUB_VERTEX   = 3'd2;
  localparam logic [2:0] SUB_EDGE     = 3'd3;
  localparam logic [2:0] SUB_AUX      = 3'd4;
  localparam logic [1:0] CMD_MEM_RESP = 2'd2;

  typedef struct {
    int          test_id;
    logic [2:0]  subclass;
    logic [3:0]  route;
    logic [31:0] address;
    logic [31:0] rdata;
    logic        rd_mode;
    logic        rnd;
    logic [1:0]  exp_mask;
  } row_t;

  typedef struct {
    logic [1:0]  mask;
    logic [31:0] address;
    logic [3:0]  route;
    logic [2:0]  subclass;
    logic [31:0] rdata;
  } exp_t;

  logic                     ap_clk;
  logic                     areset_control;
  logic                     response_in_valid;
  logic [`CACHE_ADDR_W-1:0] response_in_address;
  logic [3:0]               response_in_route;
  logic [2:0]               response_in_subclass;
  logic [1:0]               response_in_operand;
  logic [1:0]               response_in_filter;
  logic [1:0]               response_in_alu;
  logic [`CACHE_DATA_W-1:0] response_in_rdata;
  logic                     read_enable;
  logic [NREQ-1:0]          response_out_valid;
  logic [`CACHE_ADDR_W-1:0] response_out_address [NREQ];
  logic [3:0]               response_out_route [NREQ];
  logic [2:0]               response_out_subclass [NREQ];
  logic [1:0]               response_out_cmd [NREQ];
  logic [`CACHE_DATA_W-1:0] response_out_field_0 [NREQ];
  logic [`CACHE_DATA_W-1:0] response_out_field_1 [NREQ];
  logic [`CACHE_DATA_W-1:0] response_out_field_2 [NREQ];
  logic [`CACHE_DATA_W-1:0] response_out_field_3 [NREQ];
  logic                     fifo_full;
  logic                     fifo_prog_full;
  logic                     fifo_empty_n;
  logic                     fifo_setup_signal;

  row_t        tbl [$];
  exp_t        exp_q [$];
  int          model_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errs_start = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          wait_n;
  logic [31:0] rng_state = 32'd10011;

  cache_response_top i_cache_response_top (.*);

  // 4 ns clock
  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  // Run limit scales with the table length
  always @(posedge ap_clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run did not complete within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y ^= y << 13;
    y ^= y >> 17;
    y ^= y << 5;
    return y;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("Mismatch %s exp 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  // CU setup fans out to both requestors, the rest to requestor 1
  task automatic add_row(input int id, input logic [2:0] sub, input logic [3:0] route,
                         input logic [31:0] addr, input logic [31:0] data,
                         input logic mode, input logic rnd);
    row_t r;
    r.test_id  = id;
    r.subclass = sub;
    r.route    = route;
    r.address  = addr;
    r.rdata    = data;
    r.rd_mode  = mode;
    r.rnd      = rnd;
    r.exp_mask = (sub == SUB_CU_SETUP) ? 2'b11 : 2'b10;
    tbl.push_back(r);
  endtask

  task automatic build_table();
    add_row(2, SUB_VERTEX, 4'd3, 32'h0000_1000, 32'hA5A5_0001, 1'b1, 1'b0);
    add_row(2, SUB_EDGE, 4'd5, 32'h0000_1004, 32'h5A5A_0002, 1'b1, 1'b0);
    add_row(2, SUB_AUX, 4'd9, 32'h0000_1008, 32'hDEAD_0003, 1'b1, 1'b0);
    add_row(3, SUB_CU_SETUP, 4'd1, 32'h0000_2000, 32'hC0DE_0001, 1'b1, 1'b0);
    add_row(3, SUB_CU_SETUP, 4'd2, 32'h0000_2004, 32'hC0DE_0002, 1'b1, 1'b0);
    // Back-pressure rows with mixed classes
    for (int k = 0; k < 10; k++) begin
      add_row(4, (k % 3 == 0) ? SUB_CU_SETUP : SUB_VERTEX, 4'(k), 32'h3000 + 4 * k,
              32'h4000_0000 + k, 1'b0, 1'b0);
    end
    // Overfill where the last four are dropped
    for (int k = 0; k < 20; k++) begin
      add_row(5, (k % 2 == 0) ? SUB_EDGE : SUB_AUX, 4'(15 - k), 32'h5000 + 4 * k,
              32'h5000_0000 + k, 1'b0, 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      add_row(6, (k % 2 == 0) ? SUB_CU_SETUP : SUB_VERTEX, 4'(k + 7), '0, '0, 1'b1, 1'b1);
    end
  endtask

  // One row per cycle and the model takes it while space remains
  task automatic apply_rows(input int id);
    logic [31:0] addr;
    logic [31:0] data;
    exp_t        e;
    foreach (tbl[i]) begin
      if (tbl[i].test_id == id) begin
        addr = tbl[i].address;
        data = tbl[i].rdata;
        if (tbl[i].rnd) begin
          rng_state = xorshift32(rng_state);
          addr = rng_state;
          rng_state = xorshift32(rng_state);
          data = rng_state;
        end
        @(posedge ap_clk);
        #0.5;
        read_enable          = tbl[i].rd_mode;
        response_in_valid    = 1'b1;
        response_in_address  = addr;
        response_in_route    = tbl[i].route;
        response_in_subclass = tbl[i].subclass;
        response_in_operand  = 2'(i);
        response_in_filter   = 2'(i + 1);
        response_in_alu      = 2'(i + 2);
        response_in_rdata    = data;
        if (model_count < DEPTH) begin
          e.mask     = tbl[i].exp_mask;
          e.address  = addr;
          e.route    = tbl[i].route;
          e.subclass = tbl[i].subclass;
          e.rdata    = data;
          exp_q.push_back(e);
          model_count++;
        end
      end
    end
    @(posedge ap_clk);
    #0.5;
    response_in_valid = 1'b0;
  endtask

  task automatic set_read(input logic level);
    @(posedge ap_clk);
    #0.5;
    read_enable = level;
  endtask

  // Let pending outputs land, then watch for strays
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge ap_clk);
    end
    repeat (6) @(negedge ap_clk);
  endtask

  task automatic report_test(input int id, input string name);
    tests++;
    $display("Test %0d %s: %s, %0d errors", id, name,
             (errors == errs_start) ? "ok" : "failed", errors - errs_start);
    errs_start = errors;
  endtask

  task automatic compare_packet(input exp_t e);
    check("response_out_valid", e.mask, response_out_valid);
    for (int r = 0; r < NREQ; r++) begin
      if (e.mask[r]) begin
        check($sformatf("response_out_address[%0d]", r), e.address, response_out_address[r]);
        check($sformatf("response_out_route[%0d]", r), e.route, response_out_route[r]);
        check($sformatf("response_out_subclass[%0d]", r), e.subclass,
              response_out_subclass[r]);
        check($sformatf("response_out_cmd[%0d]", r), CMD_MEM_RESP, response_out_cmd[r]);
        check($sformatf("response_out_field_0[%0d]", r), e.rdata, response_out_field_0[r]);
        check($sformatf("response_out_field_1[%0d]", r), e.rdata, response_out_field_1[r]);
        check($sformatf("response_out_field_2[%0d]", r), e.rdata, response_out_field_2[r]);
        check($sformatf("response_out_field_3[%0d]", r), e.rdata, response_out_field_3[r]);
      end
    end
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------
  always @(negedge ap_clk) begin
    exp_t e;
    if (!areset_control && response_out_valid != '0) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output 0x%0h with no response pending", response_out_valid);
      end else begin
        e = exp_q.pop_front();
        model_count--;
        compare_packet(e);
      end
    end
  end

  initial begin
    areset_control       = 1'b1;
    response_in_valid    = 1'b0;
    response_in_address  = '0;
    response_in_route    = '0;
    response_in_subclass = '0;
    response_in_operand  = '0;
    response_in_filter   = '0;
    response_in_alu      = '0;
    response_in_rdata    = '0;
    read_enable          = 1'b0;
    build_table();
    cycle_limit = tbl.size() * 8 + 200;

    // Setup high, status low and outputs quiet through reset
    for (int c = 0; c < 15; c++) begin
      @(negedge ap_clk);
      if (c >= 1) begin
        check("fifo_setup_signal", 1'b1, fifo_setup_signal);
        check("response_out_valid", '0, response_out_valid);
        check("fifo_full", 1'b0, fifo_full);
        check("fifo_prog_full", 1'b0, fifo_prog_full);
        check("fifo_empty_n", 1'b0, fifo_empty_n);
      end
    end
    @(posedge ap_clk);
    #0.5;
    areset_control = 1'b0;
    wait_n = 0;
    while (fifo_setup_signal === 1'b1 && wait_n < BUSY + 4) begin
      @(negedge ap_clk);
      check("response_out_valid", '0, response_out_valid);
      wait_n++;
    end
    if (fifo_setup_signal !== 1'b0) begin
      errors++;
      $display("fifo_setup_signal did not fall within %0d cycles after reset", BUSY + 4);
    end else if (wait_n < BUSY) begin
      errors++;
      $display("fifo_setup_signal fell after %0d cycles, inside the %0d-cycle clearing window",
               wait_n, BUSY);
    end
    report_test(1, "setup signal");

    apply_rows(2);
    drain();
    report_test(2, "non-setup routing");

    apply_rows(3);
    drain();
    report_test(3, "setup routing");

    // Stall, then drain in input order
    apply_rows(4);
    repeat (4) @(negedge ap_clk);
    check("fifo_prog_full", 1'b1, fifo_prog_full);
    check("fifo_full", 1'b0, fifo_full);
    check("fifo_empty_n", 1'b1, fifo_empty_n);
    check("pending responses", 10, exp_q.size());
    set_read(1'b1);
    drain();
    check("fifo_empty_n", 1'b0, fifo_empty_n);
    check("fifo_prog_full", 1'b0, fifo_prog_full);
    report_test(4, "ordering and back-pressure");

    apply_rows(5);
    repeat (4) @(negedge ap_clk);
    check("fifo_full", 1'b1, fifo_full);
    check("pending responses", DEPTH, exp_q.size());
    set_read(1'b1);
    drain();
    check("fifo_empty_n", 1'b0, fifo_empty_n);
    check("fifo_full", 1'b0, fifo_full);
    report_test(5, "full FIFO");

    // Reads on an empty FIFO, then a held-read stream
    set_read(1'b1);
    repeat (12) @(negedge ap_clk);
    apply_rows(6);
    drain();
    report_test(6, "empty reads and streaming");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+common
common/cache_pkg.sv
common/response_fifo_if.sv
hw/response_control.sv
hw/response_fifo/response_fifo.sv
hw/response_router.sv
hw/cache_response_top.sv
verif/tb_cache_response.sv

// ==== Bender.yml ====
package:
  name: cache_response

export_include_dirs:
  - common

sources:
  - common/cache_pkg.sv
  - common/response_fifo_if.sv
  - hw/response_control.sv
  - hw/response_fifo/response_fifo.sv
  - hw/response_router.sv
  - hw/cache_response_top.sv
  - target: simulation
    files:
      - verif/tb_cache_response.sv
